// File: tb/mips_trace.txt
# P: program word in load order. D: expected display value in order.
# R: register index and final value. M: byte address and final word. All hex.
P 3C081234  # lui   t0, 0x1234
P 35085678  # ori   t0, t0, 0x5678
P 2409FFFB  # addiu t1, zero, -5
P 240A0003  # addiu t2, zero, 3
P 012A5821  # addu  t3, t1, t2
P 01496023  # subu  t4, t2, t1
P 01096826  # xor   t5, t0, t1
P 01407027  # nor   t6, t2, zero
P 012A782A  # slt   t7, t1, t2
P 012A802B  # sltu  s0, t1, t2
P 000A8900  # sll   s1, t2, 4
P 00099702  # srl   s2, t1, 28
P 00099843  # sra   s3, t1, 1
P 3134F0F0  # andi  s4, t1, 0xf0f0
P 3955FF00  # xori  s5, t2, 0xff00
P 2936FFFC  # slti  s6, t1, -4
P 24000007  # addiu zero, zero, 7
P 010AB825  # or    s7, t0, t2
P AC080010  # sw    t0, 16(zero)
P AC0B0014  # sw    t3, 20(zero)
P 8C190010  # lw    t9, 16(zero)
P 8C180014  # lw    t8, 20(zero)
P 24020001  # addiu v0, zero, 1
P 24040000  # addiu a0, zero, 0
P 241A0003  # addiu k0, zero, 3
P 0C00001F  # loop: jal count
P 149AFFFE  # bne   a0, k0, loop
P 10000001  # beq   zero, zero, out
P 24040063  # addiu a0, zero, 99 (skipped)
P 08000022  # out: j fin
P 2404004D  # addiu a0, zero, 77 (skipped)
P 24840001  # count: addiu a0, a0, 1
P 0000000C  # syscall (print)
P 03E00008  # jr    ra
P AC040018  # fin: sw a0, 24(zero)
P 2402000A  # addiu v0, zero, 10
P 0000000C  # syscall (halt)
P 24040037  # addiu a0, zero, 55 (never runs)
D 00000001
D 00000002
D 00000003
R 00 00000000
R 02 0000000A
R 04 00000003
R 08 12345678
R 09 FFFFFFFB
R 0A 00000003
R 0B FFFFFFFE
R 0C 00000008
R 0D EDCBA983
R 0E FFFFFFFC
R 0F 00000001
R 10 00000000
R 11 00000030
R 12 0000000F
R 13 FFFFFFFD
R 14 0000F0F0
R 15 0000FF03
R 16 00000001
R 17 1234567B
R 18 FFFFFFFE
R 19 12345678
R 1A 00000003
R 1F 00000068
M 00000010 12345678
M 00000014 FFFFFFFE
M 00000018 00000003

// File: vlog.f
src/mips_pkg.sv
src/fetch_unit.sv
src/control_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/mem_writeback.sv
src/mips_core.sv
tb/mips_core_tb.sv

// File: tb/mips_core_tb.sv
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int run_timeout = 2000;
    localparam int halt_hold   = 50;

    logic      clk;
    logic      arst_n;
    logic      en;
    logic      prog_we;
    imem_idx_t prog_addr;
    word_t     prog_data;
    reg_idx_t  reg_dbg_idx;
    word_t     mem_dbg_addr;
    word_t     reg_dbg_data;
    word_t     mem_dbg_data;
    word_t     display;
    logic      display_en;
    logic      halt;

    word_t    prog_q[$];
    word_t    disp_exp[$];
    word_t    disp_got[$];
    reg_idx_t reg_idx_q[$];
    word_t    reg_val_q[$];
    word_t    mem_addr_q[$];
    word_t    mem_val_q[$];
    int       errors;

    mips_core mips_core_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (en),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .reg_dbg_idx  (reg_dbg_idx),
        .mem_dbg_addr (mem_dbg_addr),
        .reg_dbg_data (reg_dbg_data),
        .mem_dbg_data (mem_dbg_data),
        .display      (display),
        .display_en   (display_en),
        .halt         (halt)
    );

    always #5 clk = ~clk;

    // A display pulse spans one full cycle, so exactly one falling edge sees it.
    always @(negedge clk) begin
        if (arst_n === 1'b1 && display_en === 1'b1) begin
            disp_got.push_back(display);
        end
    end

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic read_trace();
        int                 fd;
        int                 n;
        logic [7:0]         tag;
        word_t              a;
        word_t              b;
        logic [8*128-1:0]   rest;
        fd = $fopen("tb/mips_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file tb/mips_trace.txt");
            errors++;
        end else begin
            n = $fscanf(fd, " %c", tag);
            while (n == 1) begin
                case (tag)
                    "P": if ($fscanf(fd, " %h", a) == 1) prog_q.push_back(a);
                    "D": if ($fscanf(fd, " %h", a) == 1) disp_exp.push_back(a);
                    "R": if ($fscanf(fd, " %h %h", a, b) == 2) begin
                        reg_idx_q.push_back(reg_idx_t'(a));
                        reg_val_q.push_back(b);
                    end
                    "M": if ($fscanf(fd, " %h %h", a, b) == 2) begin
                        mem_addr_q.push_back(a);
                        mem_val_q.push_back(b);
                    end
                    "#": ; // Comment line.
                    default: begin
                        $display("unknown tag %c in the trace file", tag);
                        errors++;
                    end
                endcase
                n = $fgets(rest, fd); // Drops the rest of the line.
                n = $fscanf(fd, " %c", tag);
            end
            $fclose(fd);
        end
        if (prog_q.size() == 0 || disp_exp.size() == 0 ||
            reg_idx_q.size() == 0 || mem_addr_q.size() == 0) begin
            $display("the trace file lacks program, display, register or memory entries");
            errors++;
        end
    endtask

    initial begin
        int seed_val;
        int junk;
        int cycles;
        int idle;
        int pause;
        bit ok;
        seed_val = 41848;
        junk = $urandom(seed_val);
        errors = 0;
        ok = 1'b1;
        clk = 1'b0;
        arst_n = 1'b0;
        en = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        reg_dbg_idx = '0;
        mem_dbg_addr = '0;
        read_trace();

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        compare_value("halt", halt, 32'd0);
        compare_value("display_en", display_en, 32'd0);
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            reg_dbg_idx = reg_idx_t'(i);
            @(posedge clk);
            compare_value($sformatf("reg[%0d]", i), reg_dbg_data, '0);
        end

        // Program load with random gaps, core disabled.
        foreach (prog_q[i]) begin
            @(negedge clk);
            prog_we = 1'b1;
            prog_addr = imem_idx_t'(i);
            prog_data = prog_q[i];
            @(negedge clk);
            prog_we = 1'b0;
            idle = $urandom % 3;
            repeat (idle) @(negedge clk);
        end
        @(negedge clk);
        en = 1'b1;

        cycles = 0;
        while (display_en !== 1'b1 && cycles < run_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (display_en !== 1'b1) begin
            $display("timeout: no display pulse within %0d cycles", run_timeout);
            errors++;
            ok = 1'b0;
        end else begin
            // Long enough that a core still running would print again and halt.
            pause = 20 + ($urandom % 10);
            en = 1'b0;
            repeat (pause) begin
                @(negedge clk);
                compare_value("halt", halt, 32'd0);
                compare_value("display_en", display_en, 32'd0);
            end
            en = 1'b1;
        end

        if (ok) begin
            cycles = 0;
            while (halt !== 1'b1 && cycles < run_timeout) begin
                @(negedge clk);
                cycles++;
            end
            if (halt !== 1'b1) begin
                $display("timeout: halt did not rise within %0d cycles", run_timeout);
                errors++;
                ok = 1'b0;
            end
        end

        if (ok) begin
            repeat (halt_hold) begin
                @(negedge clk);
                compare_value("halt", halt, 32'd1);
                compare_value("display_en", display_en, 32'd0);
            end
            if (disp_got.size() != disp_exp.size()) begin
                $display("saw %0d display pulses, expected %0d", disp_got.size(), disp_exp.size());
                errors++;
            end
            foreach (disp_exp[i]) begin
                if (i < disp_got.size()) begin
                    compare_value($sformatf("display[%0d]", i), disp_got[i], disp_exp[i]);
                end
            end
            foreach (reg_idx_q[i]) begin
                @(negedge clk);
                reg_dbg_idx = reg_idx_q[i];
                @(posedge clk);
                compare_value($sformatf("reg[%0d]", reg_idx_q[i]), reg_dbg_data, reg_val_q[i]);
            end
            foreach (mem_addr_q[i]) begin
                @(negedge clk);
                mem_dbg_addr = mem_addr_q[i];
                @(posedge clk);
                compare_value($sformatf("mem[%h]", mem_addr_q[i]), mem_dbg_data, mem_val_q[i]);
            end
        end

        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/mips_core.sv
`default_nettype none

module mips_core import mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      en,
    input  logic      prog_we,
    input  imem_idx_t prog_addr,
    input  word_t     prog_data,
    input  reg_idx_t  reg_dbg_idx,
    input  word_t     mem_dbg_addr,
    output word_t     reg_dbg_data,
    output word_t     mem_dbg_data,
    output word_t     display,
    output logic      display_en,
    output logic      halt
);

    fetch_t   fetch;
    ctrl_t    ctrl;
    fields_t  fields;
    word_t    rs_data;
    word_t    rt_data;
    word_t    v0_data;
    word_t    a0_data;
    word_t    alu_res;
    word_t    pc_next;
    word_t    wb_data;
    reg_idx_t wr_idx;
    logic     reg_we_eff;
    logic     run;

    fetch_unit fetch_unit_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .pc_next   (pc_next),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fetch     (fetch)
    );

    control_decoder control_decoder_i (
        .inst   (fetch.inst),
        .ctrl   (ctrl),
        .fields (fields)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .we       (reg_we_eff),
        .wr_idx   (wr_idx),
        .wr_data  (wb_data),
        .rs_idx   (fields.rs),
        .rt_idx   (fields.rt),
        .dbg_idx  (reg_dbg_idx),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .dbg_data (reg_dbg_data),
        .v0_data  (v0_data),
        .a0_data  (a0_data)
    );

    exec_unit exec_unit_i (
        .ctrl    (ctrl),
        .fields  (fields),
        .fetch   (fetch),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .alu_res (alu_res),
        .pc_next (pc_next)
    );

    mem_writeback mem_writeback_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (en),
        .ctrl         (ctrl),
        .fields       (fields),
        .fetch        (fetch),
        .alu_res      (alu_res),
        .rt_data      (rt_data),
        .v0_data      (v0_data),
        .a0_data      (a0_data),
        .mem_dbg_addr (mem_dbg_addr),
        .mem_dbg_data (mem_dbg_data),
        .wr_idx       (wr_idx),
        .wb_data      (wb_data),
        .reg_we_eff   (reg_we_eff),
        .run          (run),
        .display      (display),
        .display_en   (display_en),
        .halt         (halt)
    );

endmodule

`default_nettype wire

// File: src/mem_writeback.sv
`default_nettype none

module mem_writeback import mips_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     en,
    input  ctrl_t    ctrl,
    input  fields_t  fields,
    input  fetch_t   fetch,
    input  word_t    alu_res,
    input  word_t    rt_data,
    input  word_t    v0_data,
    input  word_t    a0_data,
    input  word_t    mem_dbg_addr,
    output word_t    mem_dbg_data,
    output reg_idx_t wr_idx,
    output word_t    wb_data,
    output logic     reg_we_eff,
    output logic     run,
    output word_t    display,
    output logic     display_en,
    output logic     halt
);

    word_t     dmem [dmem_words];
    dmem_idx_t dm_idx;
    dmem_idx_t dbg_idx;
    word_t     mem_rdata;
    logic      print_req;
    logic      halt_req;

    assign run = en && !halt;

    assign dm_idx       = alu_res[9:2];
    assign dbg_idx      = mem_dbg_addr[9:2];
    assign mem_rdata    = dmem[dm_idx];
    assign mem_dbg_data = dmem[dbg_idx];

    always_ff @(posedge clk) begin
        if (run && ctrl.mem_we) begin
            dmem[dm_idx] <= rt_data;
        end
    end

    always_comb begin
        case (ctrl.dst_sel)
            dst_rt:  wr_idx = fields.rt;
            dst_ra:  wr_idx = reg_ra;
            default: wr_idx = fields.rd;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = mem_rdata;
            wb_pc4:  wb_data = fetch.pc_4; // Return address for jal.
            default: wb_data = alu_res;
        endcase
    end

    assign reg_we_eff = run && ctrl.reg_we;

    // Unknown v0 codes retire as a plain nop.
    assign print_req = run && ctrl.syscall && (v0_data == sys_print);
    assign halt_req  = run && ctrl.syscall && (v0_data == sys_halt);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            display    <= '0;
            display_en <= 1'b0;
            halt       <= 1'b0;
        end else begin
            display_en <= print_req;
            if (print_req) begin
                display <= a0_data;
            end
            if (halt_req) begin
                halt <= 1'b1;
            end
        end
    end

    // Only word accesses exist, so a data address is always word aligned.
    word_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
            run && (ctrl.mem_we || ctrl.wb_sel == wb_mem) |-> alu_res[1:0] == 2'b00
    ) else $error("unaligned data memory access");

endmodule

`default_nettype wire

// File: src/exec_unit.sv
`default_nettype none

module exec_unit import mips_pkg::*; (
    input  ctrl_t   ctrl,
    input  fields_t fields,
    input  fetch_t  fetch,
    input  word_t   rs_data,
    input  word_t   rt_data,
    output word_t   alu_res,
    output word_t   pc_next
);

    word_t simm;
    word_t zimm;
    word_t opb;
    word_t br_target;
    word_t jmp_target;
    logic  rs_eq_rt;

    assign simm = {{16{fields.imm16[15]}}, fields.imm16};
    assign zimm = {16'h0000, fields.imm16};

    always_comb begin
        case (ctrl.alu_src)
            src_simm: opb = simm;
            src_zimm: opb = zimm;
            default:  opb = rt_data;
        endcase
    end

    // Shifts work on the rt operand, the shift amount comes from the instruction.
    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_res = rs_data + opb;
            alu_sub:  alu_res = rs_data - opb;
            alu_and:  alu_res = rs_data & opb;
            alu_or:   alu_res = rs_data | opb;
            alu_xor:  alu_res = rs_data ^ opb;
            alu_nor:  alu_res = ~(rs_data | opb);
            alu_slt:  alu_res = {31'b0, $signed(rs_data) < $signed(opb)};
            alu_sltu: alu_res = {31'b0, rs_data < opb};
            alu_sll:  alu_res = opb << fields.shamt;
            alu_srl:  alu_res = opb >> fields.shamt;
            alu_sra:  alu_res = word_t'($signed(opb) >>> fields.shamt);
            alu_lui:  alu_res = {opb[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    assign rs_eq_rt   = (rs_data == rt_data);
    assign br_target  = fetch.pc_4 + {simm[29:0], 2'b00};
    assign jmp_target = {fetch.pc_4[31:28], fields.imm26, 2'b00}; // Stays in the 256 MB region.

    always_comb begin
        case (ctrl.pc_sel)
            pc_beq:  pc_next = rs_eq_rt ? br_target : fetch.pc_4;
            pc_bne:  pc_next = rs_eq_rt ? fetch.pc_4 : br_target;
            pc_jump: pc_next = jmp_target;
            pc_jr:   pc_next = rs_data;
            default: pc_next = fetch.pc_4;
        endcase
    end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file import mips_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t dbg_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    dbg_data,
    output word_t    v0_data,
    output word_t    a0_data
);

    word_t regs [1:31]; // Register 0 is hardwired and has no storage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data  = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data  = (rt_idx == '0) ? '0 : regs[rt_idx];
    assign dbg_data = (dbg_idx == '0) ? '0 : regs[dbg_idx];

    // Syscall reads its code and argument straight from these taps.
    assign v0_data = regs[reg_v0];
    assign a0_data = regs[reg_a0];

endmodule

`default_nettype wire

// File: src/control_decoder.sv
`default_nettype none

module control_decoder import mips_pkg::*; (
    input  word_t   inst,
    output ctrl_t   ctrl,
    output fields_t fields
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode       = inst[31:26];
    assign funct        = inst[5:0];
    assign fields.rs    = inst[25:21];
    assign fields.rt    = inst[20:16];
    assign fields.rd    = inst[15:11];
    assign fields.shamt = inst[10:6];
    assign fields.imm16 = inst[15:0];
    assign fields.imm26 = inst[25:0];

    always_comb begin
        ctrl.alu_op  = alu_add;
        ctrl.alu_src = src_reg;
        ctrl.dst_sel = dst_rd;
        ctrl.wb_sel  = wb_alu;
        ctrl.pc_sel  = pc_seq;
        ctrl.reg_we  = 1'b0;
        ctrl.mem_we  = 1'b0;
        ctrl.syscall = 1'b0;
        ctrl.illegal = 1'b0;

        case (opcode)
            op_special: begin
                ctrl.reg_we = 1'b1;
                case (funct)
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_xor:  ctrl.alu_op = alu_xor;
                    fn_nor:  ctrl.alu_op = alu_nor;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    fn_sltu: ctrl.alu_op = alu_sltu;
                    fn_sll:  ctrl.alu_op = alu_sll; // All-zero word lands here as a nop.
                    fn_srl:  ctrl.alu_op = alu_srl;
                    fn_sra:  ctrl.alu_op = alu_sra;
                    fn_jr: begin
                        ctrl.reg_we = 1'b0;
                        ctrl.pc_sel = pc_jr;
                    end
                    fn_syscall: begin
                        ctrl.reg_we  = 1'b0;
                        ctrl.syscall = 1'b1;
                    end
                    default: begin
                        ctrl.reg_we  = 1'b0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui, op_lw: begin
                ctrl.reg_we  = 1'b1;
                ctrl.dst_sel = dst_rt;
                ctrl.alu_src = src_simm;
                case (opcode)
                    op_slti: ctrl.alu_op = alu_slt;
                    op_andi: ctrl.alu_op = alu_and;
                    op_ori:  ctrl.alu_op = alu_or;
                    op_xori: ctrl.alu_op = alu_xor;
                    op_lui:  ctrl.alu_op = alu_lui;
                    default: ctrl.alu_op = alu_add;
                endcase
                // Logic immediates are zero extended.
                if (opcode inside {op_andi, op_ori, op_xori, op_lui}) begin
                    ctrl.alu_src = src_zimm;
                end
                if (opcode == op_lw) begin
                    ctrl.wb_sel = wb_mem;
                end
            end
            op_sw: begin
                ctrl.alu_src = src_simm;
                ctrl.mem_we  = 1'b1;
            end
            op_beq: ctrl.pc_sel = pc_beq;
            op_bne: ctrl.pc_sel = pc_bne;
            op_j:   ctrl.pc_sel = pc_jump;
            op_jal: begin
                ctrl.pc_sel  = pc_jump;
                ctrl.reg_we  = 1'b1;
                ctrl.dst_sel = dst_ra;
                ctrl.wb_sel  = wb_pc4;
            end
            op_regimm: ctrl.illegal = 1'b1; // No regimm branch is supported.
            default:   ctrl.illegal = 1'b1;
        endcase
    end

    // No instruction both writes a register and stores to memory.
    always_comb begin
        assert final (!(ctrl.reg_we && ctrl.mem_we))
            else $error("register and memory write decoded together");
    end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none

module fetch_unit import mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      run,
    input  word_t     pc_next,
    input  logic      prog_we,
    input  imem_idx_t prog_addr,
    input  word_t     prog_data,
    output fetch_t    fetch
);

    word_t     pc;
    word_t     imem [imem_words];
    imem_idx_t rd_idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    // Program load port.
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    assign rd_idx     = pc[9:2]; // Word addressed, upper PC bits wrap.
    assign fetch.pc   = pc;
    assign fetch.pc_4 = pc + 32'd4;
    assign fetch.inst = imem[rd_idx];

    // Loading a program under a running core would change instructions mid-flight.
    prog_while_running: assert property (
        @(posedge clk) disable iff (!arst_n) !(prog_we && run)
    ) else $error("program write while the core is running");

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int imem_words = 256;
    localparam int dmem_words = 256;

    typedef logic [$clog2(imem_words)-1:0] imem_idx_t;
    typedef logic [$clog2(dmem_words)-1:0] dmem_idx_t;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01; // bltz/bgez family, not implemented.
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_sltu    = 6'h2b;

    // Fixed register numbers used by syscall and jal.
    localparam reg_idx_t reg_v0 = 5'd2;
    localparam reg_idx_t reg_a0 = 5'd4;
    localparam reg_idx_t reg_ra = 5'd31;

    localparam word_t sys_print = 32'd1;
    localparam word_t sys_halt  = 32'd10;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {src_reg, src_simm, src_zimm} alu_src_e;
    typedef enum logic [1:0] {dst_rd, dst_rt, dst_ra} dst_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;
    typedef enum logic [2:0] {pc_seq, pc_beq, pc_bne, pc_jump, pc_jr} pc_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        alu_src_e alu_src;
        dst_sel_e dst_sel;
        wb_sel_e  wb_sel;
        pc_sel_e  pc_sel;
        logic     reg_we;
        logic     mem_we;
        logic     syscall;
        logic     illegal;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pc_4;
        word_t inst;
    } fetch_t;

    typedef struct packed {
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [4:0]  shamt;
        logic [15:0] imm16;
        logic [25:0] imm26;
    } fields_t;

endpackage

`default_nettype wire
